// File: source/cp15Pkg.sv
package cp15Pkg;

  // ******************************************************************
  // Field widths
  // ******************************************************************

  localparam int dataWidth    = 32;
  localparam int crnWidth     = 4;
  localparam int opcode2Width = 3;
  localparam int crmWidth     = 4;
  localparam int addrWidth    = crnWidth + opcode2Width + crmWidth;
  localparam int maintWidth   = 6;

  // One register per CRn value
  localparam int numRegs = 1 << crnWidth;

  // ******************************************************************
  // Types
  // ******************************************************************

  typedef logic [dataWidth-1:0]    cp15Data;
  typedef logic [crnWidth-1:0]     crIndex;
  typedef logic [opcode2Width-1:0] opcode2Field;
  typedef logic [crmWidth-1:0]     crmField;

  // Address is {CRn, opcode_2, CRm} from the top bit down
  typedef logic [addrWidth-1:0] cp15Addr;

  // {flushI, flushD, cleanI, cleanD, tlbFlushI, tlbFlushD}
  typedef logic [maintWidth-1:0] maintFlags;

  // ******************************************************************
  // Register numbers
  // ******************************************************************

  localparam crIndex crId      = 4'd0;
  localparam crIndex crControl = 4'd1;
  localparam crIndex crTbase   = 4'd2;
  localparam crIndex crCache   = 4'd7;
  localparam crIndex crTlb     = 4'd8;

endpackage

// File: source/cp15ReqIf.sv
// Registered transfer from decode to the register file
interface cp15ReqIf;

  logic                 valid;
  logic                 write;
  logic                 fromMmu;
  cp15Pkg::crIndex      crn;
  cp15Pkg::opcode2Field opcode2;
  cp15Pkg::crmField     crm;
  cp15Pkg::cp15Data     wdata;

  modport driver (
    output valid,
    output write,
    output fromMmu,
    output crn,
    output opcode2,
    output crm,
    output wdata
  );

  modport execute (
    input valid,
    input write,
    input fromMmu,
    input crn,
    input opcode2,
    input crm,
    input wdata
  );

endinterface

// File: source/cp15RspIf.sv
// Register file response, one cycle per accepted transfer
interface cp15RspIf;

  logic                 valid;
  logic                 write;
  logic                 fromMmu;
  cp15Pkg::cp15Data     rdata;
  cp15Pkg::crIndex      crn;
  cp15Pkg::opcode2Field opcode2;
  cp15Pkg::crmField     crm;

  modport driver (
    output valid,
    output write,
    output fromMmu,
    output rdata,
    output crn,
    output opcode2,
    output crm
  );

  modport result (
    input valid,
    input write,
    input fromMmu,
    input rdata,
    input crn,
    input opcode2,
    input crm
  );

endinterface

// File: source/cp15Decode.sv
module cp15Decode (
  input  logic             clk,
  input  logic             reset,
  input  logic             cpuCyc,
  input  logic             cpuStb,
  input  logic             cpuWe,
  input  cp15Pkg::cp15Addr cpuAdr,
  input  cp15Pkg::cp15Data cpuDatW,
  input  logic             mmuCyc,
  input  logic             mmuStb,
  input  logic             mmuWe,
  input  cp15Pkg::cp15Addr mmuAdr,
  input  cp15Pkg::cp15Data mmuDatW,
  input  logic             cpuAck,
  input  logic             mmuAck,
  cp15ReqIf.driver         req
);

  logic             cpuBusy;
  logic             mmuBusy;
  logic             mmuTake;
  logic             cpuTake;
  cp15Pkg::cp15Addr selAdr;
  cp15Pkg::cp15Data selDatW;
  logic             selWe;

  // ******************************************************************
  // Arbitration
  // ******************************************************************

  // MMU has fixed priority and a losing CPU just keeps stb high
  assign mmuTake = mmuCyc & mmuStb & ~mmuBusy;
  assign cpuTake = cpuCyc & cpuStb & ~cpuBusy & ~mmuTake;

  assign selAdr  = mmuTake ? mmuAdr  : cpuAdr;
  assign selDatW = mmuTake ? mmuDatW : cpuDatW;
  assign selWe   = mmuTake ? mmuWe   : cpuWe;

  // A port stays busy from acceptance until its ack has been seen
  always_ff @(posedge clk) begin
    if (reset) begin
      cpuBusy <= 1'b0;
      mmuBusy <= 1'b0;
    end else begin
      if (cpuTake) begin
        cpuBusy <= 1'b1;
      end else if (cpuAck) begin
        cpuBusy <= 1'b0;
      end
      if (mmuTake) begin
        mmuBusy <= 1'b1;
      end else if (mmuAck) begin
        mmuBusy <= 1'b0;
      end
    end
  end

  // ******************************************************************
  // Request register
  // ******************************************************************

  always_ff @(posedge clk) begin
    if (reset) begin
      req.valid <= 1'b0;
    end else begin
      req.valid <= mmuTake | cpuTake;
    end
  end

  always_ff @(posedge clk) begin
    if (mmuTake | cpuTake) begin
      req.write                      <= selWe;
      req.fromMmu                    <= mmuTake;
      {req.crn, req.opcode2, req.crm} <= selAdr;
      req.wdata                      <= selDatW;
    end
  end

endmodule

// File: source/cp15RegFile.sv
module cp15RegFile #(
  parameter cp15Pkg::cp15Data idCode = '0
) (
  input  logic             clk,
  input  logic             reset,
  cp15ReqIf.execute        req,
  cp15RspIf.driver         rsp,
  output cp15Pkg::cp15Data control,
  output cp15Pkg::cp15Data tbase
);

  cp15Pkg::cp15Data rf [cp15Pkg::numRegs];
  logic             wrEn;

  // ******************************************************************
  // Register storage
  // ******************************************************************

  // c0 is the ID register and ignores writes
  assign wrEn = req.valid & req.write & (req.crn != cp15Pkg::crId);

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < cp15Pkg::numRegs; i++) begin
        rf[i] <= '0;
      end
      rf[cp15Pkg::crId] <= idCode;
    end else if (wrEn) begin
      rf[req.crn] <= req.wdata;
    end
  end

  // ******************************************************************
  // Read and pass-through to result
  // ******************************************************************

  // Read is combinational so result can register it with the write
  assign rsp.valid   = req.valid;
  assign rsp.write   = req.write;
  assign rsp.fromMmu = req.fromMmu;
  assign rsp.rdata   = rf[req.crn];
  assign rsp.crn     = req.crn;
  assign rsp.opcode2 = req.opcode2;
  assign rsp.crm     = req.crm;

  // Control and translation base feed the MMU and caches directly
  assign control = rf[cp15Pkg::crControl];
  assign tbase   = rf[cp15Pkg::crTbase];

endmodule

// File: source/cp15Respond.sv
module cp15Respond (
  input  logic               clk,
  input  logic               reset,
  cp15RspIf.result           rsp,
  output logic               cpuAck,
  output logic               mmuAck,
  output cp15Pkg::cp15Data   cpuDatR,
  output cp15Pkg::cp15Data   mmuDatR,
  output cp15Pkg::maintFlags maint
);

  // {flushI, flushD, cleanI, cleanD}
  logic [3:0]         cacheOp;
  // {tlbFlushI, tlbFlushD}
  logic [1:0]         tlbOp;
  logic               maintWrite;
  cp15Pkg::maintFlags maintNext;

  // ******************************************************************
  // Maintenance decode
  // ******************************************************************

  // Only writes with opcode_2 of 0 or 1 trigger maintenance
  assign maintWrite = rsp.valid & rsp.write & (rsp.opcode2[2:1] == 2'b00);

  always_comb begin
    cacheOp = 4'b0000;
    tlbOp   = 2'b00;
    if (maintWrite && rsp.crn == cp15Pkg::crCache) begin
      case (rsp.crm)
        4'd7:    cacheOp = 4'b1100;
        4'd5:    cacheOp = 4'b1000;
        4'd6:    cacheOp = 4'b0100;
        4'd11:   cacheOp = 4'b0011;
        4'd10:   cacheOp = 4'b0001;
        4'd15:   cacheOp = 4'b1111;
        4'd14:   cacheOp = 4'b0101;
        default: cacheOp = 4'b0000;
      endcase
    end
    if (maintWrite && rsp.crn == cp15Pkg::crTlb) begin
      case (rsp.crm)
        4'd7:    tlbOp = 2'b11;
        4'd5:    tlbOp = 2'b10;
        4'd6:    tlbOp = 2'b01;
        default: tlbOp = 2'b00;
      endcase
    end
  end

  assign maintNext = {cacheOp, tlbOp};

  // ******************************************************************
  // Acknowledge and read data
  // ******************************************************************

  // Pulses line up with the ack of the write that caused them
  always_ff @(posedge clk) begin
    if (reset) begin
      cpuAck <= 1'b0;
      mmuAck <= 1'b0;
      maint  <= '0;
    end else begin
      cpuAck <= rsp.valid & ~rsp.fromMmu;
      mmuAck <= rsp.valid & rsp.fromMmu;
      maint  <= maintNext;
    end
  end

  // Each port keeps its last read data until its next transfer
  always_ff @(posedge clk) begin
    if (rsp.valid && !rsp.fromMmu) begin
      cpuDatR <= rsp.rdata;
    end
    if (rsp.valid && rsp.fromMmu) begin
      mmuDatR <= rsp.rdata;
    end
  end

endmodule

// File: source/cp15Top.sv
module cp15Top #(
  parameter cp15Pkg::cp15Data idCode = 32'h69052d00
) (
  input  logic             clk,
  input  logic             reset,
  // CPU port, MCR and MRC transfers
  input  logic             cpuCyc,
  input  logic             cpuStb,
  input  logic             cpuWe,
  input  cp15Pkg::cp15Addr cpuAdr,
  input  cp15Pkg::cp15Data cpuDatW,
  output cp15Pkg::cp15Data cpuDatR,
  output logic             cpuAck,
  // MMU port, table walk accesses
  input  logic             mmuCyc,
  input  logic             mmuStb,
  input  logic             mmuWe,
  input  cp15Pkg::cp15Addr mmuAdr,
  input  cp15Pkg::cp15Data mmuDatW,
  output cp15Pkg::cp15Data mmuDatR,
  output logic             mmuAck,
  // System control outputs
  output cp15Pkg::cp15Data control,
  output cp15Pkg::cp15Data tbase,
  output logic             flushI,
  output logic             flushD,
  output logic             cleanI,
  output logic             cleanD,
  output logic             tlbFlushI,
  output logic             tlbFlushD
);

  cp15Pkg::maintFlags maint;

  cp15ReqIf reqBus ();
  cp15RspIf rspBus ();

  cp15Decode decodeStage (
    .clk     (clk),
    .reset   (reset),
    .cpuCyc  (cpuCyc),
    .cpuStb  (cpuStb),
    .cpuWe   (cpuWe),
    .cpuAdr  (cpuAdr),
    .cpuDatW (cpuDatW),
    .mmuCyc  (mmuCyc),
    .mmuStb  (mmuStb),
    .mmuWe   (mmuWe),
    .mmuAdr  (mmuAdr),
    .mmuDatW (mmuDatW),
    .cpuAck  (cpuAck),
    .mmuAck  (mmuAck),
    .req     (reqBus.driver)
  );

  cp15RegFile #(.idCode(idCode)) regFile (
    .clk     (clk),
    .reset   (reset),
    .req     (reqBus.execute),
    .rsp     (rspBus.driver),
    .control (control),
    .tbase   (tbase)
  );

  cp15Respond respondStage (
    .clk     (clk),
    .reset   (reset),
    .rsp     (rspBus.result),
    .cpuAck  (cpuAck),
    .mmuAck  (mmuAck),
    .cpuDatR (cpuDatR),
    .mmuDatR (mmuDatR),
    .maint   (maint)
  );

  assign {flushI, flushD, cleanI, cleanD, tlbFlushI, tlbFlushD} = maint;

endmodule

// File: dv/cp15Tb.sv
module cp15Tb;

  localparam cp15Pkg::cp15Data tbIdCode = 32'h69052d00;
  localparam logic [1:0] portCpu  = 2'd0;
  localparam logic [1:0] portMmu  = 2'd1;
  localparam logic [1:0] portBoth = 2'd2;
  // Edges to wait for an ack before giving up on a row
  localparam int ackLimit = 8;

  // In a dual row the MMU uses adr and the CPU uses adr2
  typedef struct packed {
    logic [1:0]         port;
    logic               write;
    cp15Pkg::cp15Addr   adr;
    cp15Pkg::cp15Data   wdata;
    cp15Pkg::cp15Addr   adr2;
    cp15Pkg::cp15Data   expData;
    cp15Pkg::cp15Data   expData2;
    cp15Pkg::maintFlags expMaint;
    cp15Pkg::cp15Data   expControl;
    cp15Pkg::cp15Data   expTbase;
  } rowT;

  logic clk;
  logic reset;
  logic cpuCyc, cpuStb, cpuWe, mmuCyc, mmuStb, mmuWe;
  cp15Pkg::cp15Addr cpuAdr, mmuAdr;
  cp15Pkg::cp15Data cpuDatW, mmuDatW, cpuDatR, mmuDatR;
  logic cpuAck, mmuAck;
  cp15Pkg::cp15Data control, tbase;
  logic flushI, flushD, cleanI, cleanD, tlbFlushI, tlbFlushD;
  cp15Pkg::maintFlags maintOut;

  rowT              rows[$];
  cp15Pkg::cp15Data model [16];
  cp15Pkg::cp15Data randState;
  logic             tableReady;

  cp15Top #(.idCode(tbIdCode)) u_dut (
    .clk(clk), .reset(reset),
    .cpuCyc(cpuCyc), .cpuStb(cpuStb), .cpuWe(cpuWe), .cpuAdr(cpuAdr),
    .cpuDatW(cpuDatW), .cpuDatR(cpuDatR), .cpuAck(cpuAck),
    .mmuCyc(mmuCyc), .mmuStb(mmuStb), .mmuWe(mmuWe), .mmuAdr(mmuAdr),
    .mmuDatW(mmuDatW), .mmuDatR(mmuDatR), .mmuAck(mmuAck),
    .control(control), .tbase(tbase), .flushI(flushI), .flushD(flushD),
    .cleanI(cleanI), .cleanD(cleanD), .tlbFlushI(tlbFlushI), .tlbFlushD(tlbFlushD)
  );

  assign maintOut = {flushI, flushD, cleanI, cleanD, tlbFlushI, tlbFlushD};

  always #5 clk = ~clk;

  // ******************************************************************
  // Helpers
  // ******************************************************************

  function automatic cp15Pkg::cp15Data xorshift32(input cp15Pkg::cp15Data x);
    cp15Pkg::cp15Data y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic cp15Pkg::cp15Addr mkAdr(input cp15Pkg::crIndex crn,
                                             input cp15Pkg::opcode2Field op2,
                                             input cp15Pkg::crmField crm);
    return {crn, op2, crm};
  endfunction

  function automatic cp15Pkg::crIndex crnOf(input cp15Pkg::cp15Addr a);
    return a[cp15Pkg::addrWidth-1 -: cp15Pkg::crnWidth];
  endfunction

  task automatic stopRun(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic checkData(input string name, input cp15Pkg::cp15Data got,
                           input cp15Pkg::cp15Data exp);
    if (got !== exp) begin
      stopRun($sformatf("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic checkMaint(input string name, input cp15Pkg::maintFlags got,
                            input cp15Pkg::maintFlags exp);
    if (got !== exp) begin
      stopRun($sformatf("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  task automatic verifyLatency(input string name, input int got, input int exp);
    if (got != exp) begin
      stopRun($sformatf("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, exp));
    end
  endtask

  // ******************************************************************
  // Stimulus table
  // ******************************************************************

  // Expected values come from the register model as rows are added in order
  task automatic addRow(input logic [1:0] port, input logic write,
                        input cp15Pkg::cp15Addr adr, input cp15Pkg::cp15Data wdata,
                        input cp15Pkg::cp15Addr adr2, input cp15Pkg::maintFlags expMaint);
    rowT r;
    r.port     = port;
    r.write    = write;
    r.adr      = adr;
    r.wdata    = wdata;
    r.adr2     = adr2;
    r.expData  = model[crnOf(adr)];
    r.expData2 = model[crnOf(adr2)];
    r.expMaint = expMaint;
    if (write && crnOf(adr) != cp15Pkg::crId) begin
      model[crnOf(adr)] = wdata;
    end
    r.expControl = model[cp15Pkg::crControl];
    r.expTbase   = model[cp15Pkg::crTbase];
    rows.push_back(r);
  endtask

  task automatic addRandWrite(input logic [1:0] port, input cp15Pkg::cp15Addr adr);
    randState = xorshift32(randState);
    addRow(port, 1'b1, adr, randState, '0, '0);
  endtask

  // Opcode_2 of 0 and 1 pulse, 2 does not, and a read never does
  task automatic addMaintCode(input cp15Pkg::crIndex crn, input cp15Pkg::crmField crm,
                              input cp15Pkg::maintFlags flags, input logic [1:0] port);
    for (int op = 0; op < 3; op++) begin
      randState = xorshift32(randState);
      addRow(port, 1'b1, mkAdr(crn, cp15Pkg::opcode2Field'(op), crm), randState, '0,
             (op < 2) ? flags : '0);
    end
    addRow(port, 1'b0, mkAdr(crn, 3'd0, crm), '0, '0, '0);
  endtask

  task automatic buildTable();
    for (int i = 0; i < 16; i++) begin
      model[i] = '0;
    end
    model[cp15Pkg::crId] = tbIdCode;
    addRow(portCpu, 1'b0, mkAdr(cp15Pkg::crId, 3'd0, 4'd0), '0, '0, '0);
    addRow(portCpu, 1'b0, mkAdr(cp15Pkg::crControl, 3'd0, 4'd0), '0, '0, '0);
    addRow(portMmu, 1'b0, mkAdr(cp15Pkg::crTbase, 3'd0, 4'd0), '0, '0, '0);
    addRow(portMmu, 1'b0, mkAdr(cp15Pkg::crId, 3'd0, 4'd0), '0, '0, '0);
    for (int i = 0; i < 3; i++) begin
      addRandWrite(portCpu, mkAdr(cp15Pkg::crControl, 3'd0, 4'd0));
      addRandWrite(portCpu, mkAdr(cp15Pkg::crTbase, 3'd0, 4'd0));
      addRow(portMmu, 1'b0, mkAdr(cp15Pkg::crControl, 3'd0, 4'd0), '0, '0, '0);
      addRow(portCpu, 1'b0, mkAdr(cp15Pkg::crTbase, 3'd0, 4'd0), '0, '0, '0);
    end
    addRandWrite(portCpu, mkAdr(cp15Pkg::crId, 3'd0, 4'd0));
    addRow(portMmu, 1'b0, mkAdr(cp15Pkg::crId, 3'd0, 4'd0), '0, '0, '0);
    // Cache and TLB maintenance codes
    addMaintCode(cp15Pkg::crCache, 4'd7,  6'b110000, portCpu);
    addMaintCode(cp15Pkg::crCache, 4'd5,  6'b100000, portMmu);
    addMaintCode(cp15Pkg::crCache, 4'd6,  6'b010000, portCpu);
    addMaintCode(cp15Pkg::crCache, 4'd11, 6'b001100, portMmu);
    addMaintCode(cp15Pkg::crCache, 4'd10, 6'b000100, portCpu);
    addMaintCode(cp15Pkg::crCache, 4'd15, 6'b111100, portMmu);
    addMaintCode(cp15Pkg::crCache, 4'd14, 6'b010100, portCpu);
    addMaintCode(cp15Pkg::crTlb,   4'd7,  6'b000011, portMmu);
    addMaintCode(cp15Pkg::crTlb,   4'd5,  6'b000010, portCpu);
    addMaintCode(cp15Pkg::crTlb,   4'd6,  6'b000001, portMmu);
    // Both ports in the same cycle
    addRow(portBoth, 1'b0, mkAdr(cp15Pkg::crControl, 3'd0, 4'd0), '0,
           mkAdr(cp15Pkg::crTbase, 3'd0, 4'd0), '0);
    addRow(portBoth, 1'b0, mkAdr(cp15Pkg::crTbase, 3'd0, 4'd0), '0,
           mkAdr(cp15Pkg::crId, 3'd0, 4'd0), '0);
  endtask

  // ******************************************************************
  // Drive loop
  // ******************************************************************

  // Called at a falling edge, returns at a falling edge
  task automatic applyRow(input rowT r);
    logic cpuDone;
    logic mmuDone;
    int   edges;
    cpuDone = (r.port == portMmu);
    mmuDone = (r.port == portCpu);
    if (!mmuDone) begin
      mmuCyc  = 1'b1;
      mmuStb  = 1'b1;
      mmuWe   = r.write;
      mmuAdr  = r.adr;
      mmuDatW = r.wdata;
    end
    if (!cpuDone) begin
      cpuCyc  = 1'b1;
      cpuStb  = 1'b1;
      cpuWe   = r.write;
      cpuAdr  = (r.port == portBoth) ? r.adr2 : r.adr;
      cpuDatW = r.wdata;
    end
    edges = 0;
    while (!(cpuDone && mmuDone)) begin
      @(posedge clk);
      @(negedge clk);
      edges++;
      if (edges > ackLimit) begin
        stopRun($sformatf("No ack within %0d cycles at time %0t", ackLimit, $time));
      end
      if (!mmuAck && !cpuAck) begin
        checkMaint("maint", maintOut, '0);
      end
      if (mmuAck) begin
        if (mmuDone) begin
          stopRun($sformatf("Unexpected ack on the MMU port at time %0t", $time));
        end
        verifyLatency("mmuAck latency", edges, 2);
        if (!r.write) begin
          checkData("mmuDatR", mmuDatR, r.expData);
        end
        checkMaint("maint", maintOut, r.expMaint);
        mmuDone = 1'b1;
        mmuCyc  = 1'b0;
        mmuStb  = 1'b0;
      end
      if (cpuAck) begin
        if (cpuDone) begin
          stopRun($sformatf("Unexpected ack on the CPU port at time %0t", $time));
        end
        // The CPU loses one cycle to the MMU in a dual row
        verifyLatency("cpuAck latency", edges, (r.port == portBoth) ? 3 : 2);
        if (!r.write) begin
          checkData("cpuDatR", cpuDatR, (r.port == portBoth) ? r.expData2 : r.expData);
        end
        checkMaint("maint", maintOut, r.expMaint);
        cpuDone = 1'b1;
        cpuCyc  = 1'b0;
        cpuStb  = 1'b0;
      end
    end
    @(posedge clk);
    @(negedge clk);
    if (cpuAck || mmuAck) begin
      stopRun($sformatf("Ack stayed high for more than one cycle at time %0t", $time));
    end
    checkMaint("maint", maintOut, '0);
    checkData("control", control, r.expControl);
    checkData("tbase", tbase, r.expTbase);
  endtask

  initial begin
    clk        = 1'b0;
    reset      = 1'b1;
    tableReady = 1'b0;
    randState  = 32'd86;
    cpuCyc     = 1'b0;
    cpuStb     = 1'b0;
    cpuWe      = 1'b0;
    cpuAdr     = '0;
    cpuDatW    = '0;
    mmuCyc     = 1'b0;
    mmuStb     = 1'b0;
    mmuWe      = 1'b0;
    mmuAdr     = '0;
    mmuDatW    = '0;
    buildTable();
    tableReady = 1'b1;
    repeat (10) @(negedge clk);
    reset = 1'b0;
    checkMaint("maint", maintOut, '0);
    checkData("control", control, '0);
    checkData("tbase", tbase, '0);
    foreach (rows[i]) begin
      applyRow(rows[i]);
    end
    $display("ALL CHECKS PASSED");
    $finish;
  end

  // Twenty cycles per row plus reset
  initial begin
    wait (tableReady);
    repeat (rows.size() * 20 + 20) @(posedge clk);
    stopRun($sformatf("Watchdog expired at time %0t before all rows ran", $time));
  end

endmodule

// File: build.f
source/cp15Pkg.sv
source/cp15ReqIf.sv
source/cp15RspIf.sv
source/cp15Decode.sv
source/cp15RegFile.sv
source/cp15Respond.sv
source/cp15Top.sv
dv/cp15Tb.sv
